// ==== sim/aes_stimulus.txt ====
// Each line holds key then plaintext then expected ciphertext
// One 32-digit hex value per column
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
00000000000000000000000000000000 96ab5c2ff612d9dfaae8c31f30c42168 ff4f8391a6a40ca5b25d23bedd44a597

// ==== files.f ====
+incdir+common
common/aesPkg.sv
aesCore/aesKeyStep.sv
aesCore/aesRoundUnit.sv
aesCore/aesCore.sv
design/aesWbSlave.sv
design/aesWbTop.sv
sim/aesTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= files.f
TB_TOP ?= aesTb
RTL_TOP ?= aesWbTop
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/aesTb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "aes_defs.svh"

module aesTb;
  import aesPkg::*;

  localparam int NumVec = 10;
  localparam int CycleLimit = NumVec * 80 + 200;

  logic                  clk;
  logic                  rstN;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`WB_ADDR_W-1:0] adr;
  logic [`WB_DATA_W-1:0] datIn;
  logic [`WB_DATA_W-1:0] datOut;
  logic                  ack;

  // Three entries per vector: key, plaintext, expected ciphertext
  aesStateT vecMem [0:3*NumVec-1];
  string    testName;
  int       cycleCount = 0;
  int       errorCount = 0;
  int       errorsAtStart = 0;
  int       testsPassed = 0;
  int       testsFailed = 0;

  aesWbTop u_aesWbTop
  (
    .clk    (clk),
    .rstN   (rstN),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .datIn  (datIn),
    .datOut (datOut),
    .ack    (ack)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit)
    begin
      $display("timeout: run did not finish within %0d cycles", CycleLimit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic beginTest(input string name);
    testName = name;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest();
    if (errorCount == errorsAtStart)
    begin
      testsPassed++;
      $display("test %s passed", testName);
    end
    else
    begin
      testsFailed++;
      $display("test %s failed with %0d errors", testName, errorCount - errorsAtStart);
    end
  endtask

  task automatic checkState(input string what, input aesStateT expected, input aesStateT actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkWord(input string what, input logic [`WB_DATA_W-1:0] expected,
                           input logic [`WB_DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("error %s %s: expected %b, actual %b", testName, what, expected, actual);
    end
  endtask

  task automatic idleGap();
    int gap;
    gap = $urandom_range(2);
    repeat (gap) @(posedge clk);
  endtask

  task automatic wbWrite(input logic [`WB_ADDR_W-1:0] addr, input logic [`WB_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = addr;
    datIn = data;
    do
    begin
      @(posedge clk);
      #1;
    end while (!ack);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wbRead(input logic [`WB_ADDR_W-1:0] addr, output logic [`WB_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = addr;
    do
    begin
      @(posedge clk);
      #1;
    end while (!ack);
    data = datOut;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic writeBlock(input aesStateT keyVal, input aesStateT textVal);
    for (int i = 0; i < 4; i++)
    begin
      idleGap();
      wbWrite(4'(regKey0 + i), keyVal[127 - 32*i -: 32]);
      idleGap();
      wbWrite(4'(regText0 + i), textVal[127 - 32*i -: 32]);
    end
  endtask

  task automatic readCipher(output aesStateT block);
    logic [`WB_DATA_W-1:0] word;
    block = '0;
    for (int i = 0; i < 4; i++)
    begin
      wbRead(4'(regCipher0 + i), word);
      block[127 - 32*i -: 32] = word;
    end
  endtask

  task automatic startBlock(output int ackCycle);
    wbWrite(regCtrl, 32'h1);
    ackCycle = cycleCount;
  endtask

  // Done must show up within 12 clocks of the start ack
  task automatic pollDone(input int ackCycle);
    logic [`WB_DATA_W-1:0] status;
    status = '0;
    while (!status[1] && (cycleCount - ackCycle) < 12)
    begin
      wbRead(regStatus, status);
    end
    checkFlag("done flag", 1'b1, status[1]);
    checkFlag("busy flag", 1'b0, status[0]);
  endtask

  initial
  begin
    aesStateT              result;
    logic [`WB_DATA_W-1:0] word;
    int                    ackCycle;
    void'($urandom(32'h95eb_237f));
    rstN = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    $readmemh("sim/aes_stimulus.txt", vecMem);
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;

    beginTest("reset values");
    wbRead(regStatus, word);
    checkWord("status", 32'h0, word);
    readCipher(result);
    checkState("ciphertext", '0, result);
    endTest();

    beginTest("register readback");
    writeBlock(vecMem[0], vecMem[1]);
    for (int i = 0; i < 4; i++)
    begin
      wbRead(4'(regKey0 + i), word);
      checkWord("key word", vecMem[0][127 - 32*i -: 32], word);
      wbRead(4'(regText0 + i), word);
      checkWord("text word", vecMem[1][127 - 32*i -: 32], word);
    end
    endTest();

    // Second run checks that a new start clears the done left by the first
    beginTest("status flags");
    for (int run = 0; run < 2; run++)
    begin
      startBlock(ackCycle);
      wbRead(regStatus, word);
      checkFlag("done after start", 1'b0, word[1]);
      checkFlag("busy after start", 1'b1, word[0]);
      pollDone(ackCycle);
    end
    readCipher(result);
    checkState("ciphertext", vecMem[2], result);
    endTest();

    // No gaps here so every write lands while the core is busy
    beginTest("writes while busy");
    writeBlock(vecMem[3], vecMem[4]);
    startBlock(ackCycle);
    for (int i = 0; i < 4; i++)
    begin
      wbWrite(4'(regText0 + i), $urandom());
    end
    wbWrite(regCtrl, 32'h1);
    pollDone(ackCycle);
    readCipher(result);
    checkState("ciphertext", vecMem[5], result);
    endTest();

    // All vectors back to back without reset
    for (int v = 0; v < NumVec; v++)
    begin
      beginTest($sformatf("known answer %0d", v));
      writeBlock(vecMem[3*v], vecMem[3*v + 1]);
      startBlock(ackCycle);
      pollDone(ackCycle);
      readCipher(result);
      checkState("ciphertext", vecMem[3*v + 2], result);
      endTest();
    end

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             testsPassed, testsFailed, errorCount);
    if (errorCount == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/aesWbTop.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "aes_defs.svh"

module aesWbTop
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`WB_ADDR_W-1:0] adr,
  input  logic [`WB_DATA_W-1:0] datIn,
  output logic [`WB_DATA_W-1:0] datOut,
  output logic                  ack
);
  import aesPkg::*;

  aesStateT key;
  aesStateT plainText;
  aesStateT cipherText;
  logic     start;
  logic     busy;
  logic     done;

  aesWbSlave u_slave
  (
    .clk        (clk),
    .rstN       (rstN),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .datIn      (datIn),
    .datOut     (datOut),
    .ack        (ack),
    .key        (key),
    .plainText  (plainText),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .cipherText (cipherText)
  );

  aesCore u_core
  (
    .clk        (clk),
    .rstN       (rstN),
    .start      (start),
    .key        (key),
    .plainText  (plainText),
    .busy       (busy),
    .done       (done),
    .cipherText (cipherText)
  );

endmodule

`default_nettype wire

// ==== design/aesWbSlave.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "aes_defs.svh"

module aesWbSlave
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  logic [`WB_ADDR_W-1:0]   adr,
  input  logic [`WB_DATA_W-1:0]   datIn,
  output logic [`WB_DATA_W-1:0]   datOut,
  output logic                    ack,
  output aesPkg::aesStateT        key,
  output aesPkg::aesStateT        plainText,
  output logic                    start,
  input  logic                    busy,
  input  logic                    done,
  input  aesPkg::aesStateT        cipherText
);
  import aesPkg::*;

  logic                  req;
  wbRegT                 regSel;
  logic [6:0]            wordLsb;
  aesStateT              keyReg;
  aesStateT              textReg;
  logic [`WB_DATA_W-1:0] readWord;

  // New request only while ack is low, so each cycle gets one ack
  assign req = cyc && stb && !ack;
  assign regSel = wbRegT'(adr);
  // Word 0 sits in the top bits of the block
  assign wordLsb = {~adr[1:0], 5'b00000};
  assign key = keyReg;
  assign plainText = textReg;

  always_comb
  begin
    case (regSel)
      regKey0, regKey1, regKey2, regKey3:
        readWord = keyReg[wordLsb +: 32];
      regText0, regText1, regText2, regText3:
        readWord = textReg[wordLsb +: 32];
      regStatus:
        readWord = {{(`WB_DATA_W-2){1'b0}}, done, busy};
      regCipher0, regCipher1, regCipher2, regCipher3:
        readWord = cipherText[wordLsb +: 32];
      // Ctrl is write-only
      default:
        readWord = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      ack <= 1'b0;
      start <= 1'b0;
      datOut <= '0;
      keyReg <= '0;
      textReg <= '0;
    end
    else
    begin
      ack <= req;
      start <= req && we && (regSel == regCtrl) && datIn[0] && !busy;
      if (req && we)
      begin
        case (regSel)
          regKey0, regKey1, regKey2, regKey3:
            keyReg[wordLsb +: 32] <= datIn;
          regText0, regText1, regText2, regText3:
            textReg[wordLsb +: 32] <= datIn;
          default:
            ;
        endcase
      end
      if (req && !we)
      begin
        datOut <= readWord;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack);

  // Core must still be idle while the pulse is high
  assert property (@(posedge clk) disable iff (!rstN) start |-> !busy);

endmodule

`default_nettype wire

// ==== aesCore/aesCore.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "aes_defs.svh"

module aesCore
(
  input  logic             clk,
  input  logic             rstN,
  input  logic             start,
  input  aesPkg::aesStateT key,
  input  aesPkg::aesStateT plainText,
  output logic             busy,
  output logic             done,
  output aesPkg::aesStateT cipherText
);
  import aesPkg::*;

  aesPhaseT   phase;
  logic [3:0] roundCnt;
  aesStateT   stateReg;
  aesStateT   roundKey;
  aesByteT    rcon;
  aesStateT   nextKey;
  aesStateT   roundOut;
  logic       lastRound;

  assign busy = (phase != phIdle);
  assign lastRound = (phase == phLast);

  aesKeyStep u_keyStep
  (
    .prevKey (roundKey),
    .rcon    (rcon),
    .nextKey (nextKey)
  );

  // Round r uses the key derived in the same cycle
  aesRoundUnit u_round
  (
    .state     (stateReg),
    .roundKey  (nextKey),
    .lastRound (lastRound),
    .result    (roundOut)
  );

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      phase <= phIdle;
      roundCnt <= 4'd0;
      stateReg <= '0;
      roundKey <= '0;
      rcon <= 8'h00;
      cipherText <= '0;
      done <= 1'b0;
    end
    else
    begin
      case (phase)
        phIdle:
        begin
          if (start)
          begin
            // Initial AddRoundKey
            stateReg <= plainText ^ key;
            roundKey <= key;
            rcon <= 8'h01;
            roundCnt <= 4'd1;
            done <= 1'b0;
            phase <= phRound;
          end
        end
        phRound:
        begin
          stateReg <= roundOut;
          roundKey <= nextKey;
          rcon <= xTime(rcon);
          roundCnt <= roundCnt + 4'd1;
          if (roundCnt == 4'(`AES_NR - 1))
          begin
            phase <= phLast;
          end
        end
        phLast:
        begin
          cipherText <= roundOut;
          done <= 1'b1;
          roundCnt <= 4'd0;
          phase <= phIdle;
        end
        default:
          phase <= phIdle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    (phase == phLast) == (roundCnt == 4'(`AES_NR)));

endmodule

`default_nettype wire

// ==== aesCore/aesRoundUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

module aesRoundUnit
(
  input  aesPkg::aesStateT state,
  input  aesPkg::aesStateT roundKey,
  input  logic             lastRound,
  output aesPkg::aesStateT result
);
  import aesPkg::*;

  aesStateT subState;
  aesStateT shiftState;
  aesStateT mixState;

  function automatic aesWordT mixColumn(aesWordT col);
    aesByteT a0;
    aesByteT a1;
    aesByteT a2;
    aesByteT a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {
      xTime(a0) ^ xTime(a1) ^ a1 ^ a2 ^ a3,
      a0 ^ xTime(a1) ^ xTime(a2) ^ a2 ^ a3,
      a0 ^ a1 ^ xTime(a2) ^ xTime(a3) ^ a3,
      xTime(a0) ^ a0 ^ a1 ^ a2 ^ xTime(a3)
    };
  endfunction

  always_comb
  begin
    for (int n = 0; n < 16; n++)
    begin
      subState[127 - 8*n -: 8] = sBox(state[127 - 8*n -: 8]);
    end
  end

  // Byte n is row n%4 of column n/4; row r rotates left by r
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shiftState[127 - 8*(4*c + r) -: 8] = subState[127 - 8*(4*((c + r) % 4) + r) -: 8];
      end
    end
  end

  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixState[127 - 32*c -: 32] = mixColumn(shiftState[127 - 32*c -: 32]);
    end
  end

  // Final round has no MixColumns
  assign result = (lastRound ? shiftState : mixState) ^ roundKey;

endmodule

`default_nettype wire

// ==== aesCore/aesKeyStep.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "aes_defs.svh"

module aesKeyStep
(
  input  aesPkg::aesStateT prevKey,
  input  aesPkg::aesByteT  rcon,
  output aesPkg::aesStateT nextKey
);
  import aesPkg::*;

  aesWordT rotWord;
  aesWordT mixWord;
  aesWordT chain;

  // RotWord on the last key word
  assign rotWord = {prevKey[23:0], prevKey[31:24]};

  assign mixWord = {
    sBox(rotWord[31:24]) ^ rcon,
    sBox(rotWord[23:16]),
    sBox(rotWord[15:8]),
    sBox(rotWord[7:0])
  };

  // Each new word is the old word xor the new word before it
  always_comb
  begin
    chain = mixWord;
    nextKey = '0;
    for (int i = 0; i < `AES_NK; i++)
    begin
      chain = chain ^ prevKey[32*(`AES_NK-1-i) +: 32];
      nextKey[32*(`AES_NK-1-i) +: 32] = chain;
    end
  end

endmodule

`default_nettype wire

// ==== common/aesPkg.sv ====
`default_nettype none

package aesPkg;

  // Column-major block, byte 0 in the top bits
  typedef logic [127:0] aesStateT;
  typedef logic [31:0] aesWordT;
  typedef logic [7:0] aesByteT;

  typedef enum logic [1:0] {phIdle, phRound, phLast} aesPhaseT;

  typedef enum logic [3:0] {
    regKey0    = 4'd0,
    regKey1    = 4'd1,
    regKey2    = 4'd2,
    regKey3    = 4'd3,
    regText0   = 4'd4,
    regText1   = 4'd5,
    regText2   = 4'd6,
    regText3   = 4'd7,
    regCtrl    = 4'd8,
    regStatus  = 4'd9,
    regCipher0 = 4'd12,
    regCipher1 = 4'd13,
    regCipher2 = 4'd14,
    regCipher3 = 4'd15
  } wbRegT;

  function automatic aesByteT xTime(aesByteT a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic aesByteT gfMul(aesByteT a, aesByteT b);
    aesByteT acc;
    aesByteT term;
    acc = 8'h00;
    term = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        acc = acc ^ term;
      end
      term = xTime(term);
    end
    return acc;
  endfunction

  // Inverse as x^254, zero maps to zero
  function automatic aesByteT sBox(aesByteT x);
    aesByteT power;
    aesByteT inv;
    power = x;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      power = gfMul(power, power);
      inv = gfMul(inv, power);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

endpackage

`default_nettype wire

// ==== common/aes_defs.svh ====
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// AES-128 only
`define AES_NR 10
`define AES_NK 4

// Wishbone word bus
`define WB_ADDR_W 4
`define WB_DATA_W 32

`endif
